//--- spi_flash_pkg.sv
package spi_flash_pkg;

    // host side widths
    localparam int data_w  = 32;
    localparam int cmd_w   = 8;
    localparam int addr_w  = 32;
    localparam int ctype_w = 3;
    localparam int nbits_w = 6;   // holds 8 to 32
    localparam int dummy_w = 4;

    // command + 32-bit address + 32 data bits
    localparam int frame_w = cmd_w + addr_w + data_w;

    localparam int addr_bits_short = 24;
    localparam int addr_bits_long  = 32;

    // wide enough for the longest frame including dummies
    localparam int cycle_w = 8;

    // request types
    localparam logic [ctype_w-1:0] ctype_cmd      = 3'd0;  // command only
    localparam logic [ctype_w-1:0] ctype_cmd_rd   = 3'd1;  // command, read
    localparam logic [ctype_w-1:0] ctype_addr_rd  = 3'd2;  // command, addr, dummy, read
    localparam logic [ctype_w-1:0] ctype_cmd_wr   = 3'd3;  // command, write
    localparam logic [ctype_w-1:0] ctype_addr_wr  = 3'd4;  // command, addr, write
    localparam logic [ctype_w-1:0] ctype_cmd_addr = 3'd5;  // command, addr

endpackage

//--- spi_clock_pkg.sv
package spi_clock_pkg;

    // system clocks per serial half period
    localparam int clks_per_half_sclk = 2;

    // mode 3
    localparam bit sclk_cpol = 1'b1;  // idle level
    localparam bit sclk_cpha = 1'b1;  // sample on trailing edge

    // divider counter, counts 0 .. clks_per_half_sclk-1
    typedef logic [$clog2(clks_per_half_sclk + 1)-1:0] half_cnt_t;

endpackage

//--- spi_sclk_gen.sv
`timescale 1ns/10ps

module spi_sclk_gen (
    input  logic                              rst,
    input  logic                              clk,
    input  logic                              start,
    input  logic [spi_flash_pkg::cycle_w-1:0] total_cycles,
    output logic                              sclk,
    output logic                              lead_edge,
    output logic                              trail_edge,
    output logic                              done
);
    import spi_flash_pkg::*;
    import spi_clock_pkg::*;

    half_cnt_t        half_cnt;
    logic [cycle_w:0] edges_left;  // two edges per serial cycle
    logic             running;
    logic             tick;

    // sclk toggles on the cycle after tick
    assign tick = running && (half_cnt == half_cnt_t'(clks_per_half_sclk - 1));

    // leaving idle level is the leading edge
    assign lead_edge  = tick && (sclk == sclk_cpol);
    assign trail_edge = tick && (sclk != sclk_cpol);

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            sclk       <= sclk_cpol;
            running    <= 1'b0;
            half_cnt   <= '0;
            edges_left <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running    <= 1'b1;
                half_cnt   <= '0;
                edges_left <= {total_cycles, 1'b0};
            end else if (running) begin
                if (tick) begin
                    half_cnt   <= '0;
                    sclk       <= ~sclk;
                    edges_left <= edges_left - 1'b1;
                    // even edge count, so sclk lands back at idle
                    if (edges_left == 1) begin
                        running <= 1'b0;
                        done    <= 1'b1;
                    end
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end
        end
    end

    a_single_edge: assert property (
        @(posedge rst) disable iff (clk)
        !(lead_edge && trail_edge)
    );

endmodule

//--- spi_frame_regs.sv
`timescale 1ns/10ps

module spi_frame_regs (
    input  logic                              rst,
    input  logic                              clk,
    input  logic                              accept,
    input  logic [spi_flash_pkg::data_w-1:0]  data_in,
    input  logic [spi_flash_pkg::addr_w-1:0]  address,
    input  logic [spi_flash_pkg::cmd_w-1:0]   command,
    input  logic [spi_flash_pkg::ctype_w-1:0] comm_type,
    input  logic [spi_flash_pkg::nbits_w-1:0] ndata_bits,
    input  logic [spi_flash_pkg::dummy_w-1:0] dummy_cycles,
    input  logic                              four_byte_addr,
    output logic [spi_flash_pkg::frame_w-1:0] tx_frame,
    output logic [spi_flash_pkg::cycle_w-1:0] tx_bits,
    output logic [spi_flash_pkg::nbits_w-1:0] rx_bits,
    output logic [spi_flash_pkg::cycle_w-1:0] total_cycles
);
    import spi_flash_pkg::*;

    logic               has_addr;
    logic               has_wr;
    logic               has_rd;
    logic               has_dummy;
    logic [cycle_w-1:0] addr_len;
    logic [cycle_w-1:0] data_len;
    logic [cycle_w-1:0] tx_len;
    logic [data_w-1:0]  wr_swapped;
    logic [frame_w-1:0] cmd_field;
    logic [frame_w-1:0] addr_field;
    logic [frame_w-1:0] data_field;
    logic [frame_w-1:0] frame_next;

    // phases carried by each request type
    always_comb begin
        has_addr  = 1'b0;
        has_wr    = 1'b0;
        has_rd    = 1'b0;
        has_dummy = 1'b0;
        case (comm_type)
            ctype_cmd_rd: has_rd = 1'b1;
            ctype_addr_rd: begin
                has_addr  = 1'b1;
                has_dummy = 1'b1;
                has_rd    = 1'b1;
            end
            ctype_cmd_wr: has_wr = 1'b1;
            ctype_addr_wr: begin
                has_addr = 1'b1;
                has_wr   = 1'b1;
            end
            ctype_cmd_addr: has_addr = 1'b1;
            default: ;  // command only
        endcase
    end

    assign addr_len = !has_addr      ? '0 :
                      four_byte_addr ? cycle_w'(addr_bits_long) : cycle_w'(addr_bits_short);
    assign data_len = cycle_w'(ndata_bits);
    assign tx_len   = cycle_w'(cmd_w) + addr_len + (has_wr ? data_len : '0);

    // low byte leaves first
    assign wr_swapped = {data_in[7:0], data_in[15:8], data_in[23:16], data_in[31:24]};

    // fields left-justified, then slid behind what precedes them
    assign cmd_field  = {command, {(frame_w - cmd_w){1'b0}}};
    assign addr_field = four_byte_addr ?
        {address, {(frame_w - addr_w){1'b0}}} :
        {address[addr_bits_short-1:0], {(frame_w - addr_bits_short){1'b0}}};
    assign data_field = {wr_swapped, {(frame_w - data_w){1'b0}}};

    assign frame_next = cmd_field
                      | (has_addr ? addr_field >> cmd_w : '0)
                      | (has_wr ? data_field >> (cmd_w + addr_len) : '0);

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            tx_bits      <= '0;
            rx_bits      <= '0;
            total_cycles <= '0;
        end else if (accept) begin
            tx_bits      <= tx_len;
            rx_bits      <= has_rd ? ndata_bits : '0;
            total_cycles <= tx_len + (has_dummy ? cycle_w'(dummy_cycles) : '0)
                          + (has_rd ? data_len : '0);
        end
    end

    always_ff @(posedge rst) begin
        if (accept) begin
            tx_frame <= frame_next;
        end
    end

    a_nbits_legal: assert property (
        @(posedge rst) disable iff (clk)
        accept |-> (ndata_bits[2:0] == 3'd0) && (ndata_bits >= 8) && (ndata_bits <= 32)
    );

endmodule

//--- spi_shift_engine.sv
`timescale 1ns/10ps

module spi_shift_engine (
    input  logic                              rst,
    input  logic                              clk,
    input  logic                              start,
    input  logic                              lead_edge,
    input  logic                              trail_edge,
    input  logic [spi_flash_pkg::frame_w-1:0] tx_frame,
    input  logic [spi_flash_pkg::cycle_w-1:0] tx_bits,
    input  logic [spi_flash_pkg::nbits_w-1:0] rx_bits,
    input  logic                              miso,
    output logic                              mosi,
    output logic [spi_flash_pkg::data_w-1:0]  read_data
);
    import spi_flash_pkg::*;
    import spi_clock_pkg::*;

    // with cpha 0 the first bit must sit on mosi before the first edge
    localparam bit early_out = (sclk_cpha == 1'b0);

    logic               shift_edge;
    logic               sample_edge;
    logic [frame_w-1:0] tx_shift;
    logic [cycle_w-1:0] tx_left;   // bits still to send
    logic [data_w-1:0]  rx_shift;
    logic [data_w-1:0]  rx_aligned;

    assign shift_edge  = sclk_cpha ? lead_edge : trail_edge;
    assign sample_edge = sclk_cpha ? trail_edge : lead_edge;

    always_ff @(posedge rst) begin
        if (start) begin
            tx_shift <= early_out ? tx_frame << 1 : tx_frame;
        end else if (shift_edge) begin
            tx_shift <= tx_shift << 1;
        end
    end

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            mosi    <= 1'b0;
            tx_left <= '0;
        end else if (start) begin
            mosi    <= early_out ? tx_frame[frame_w-1] : 1'b0;
            tx_left <= early_out ? tx_bits - 1'b1 : tx_bits;
        end else if (shift_edge) begin
            if (tx_left != '0) begin
                mosi    <= tx_shift[frame_w-1];  // msb first
                tx_left <= tx_left - 1'b1;
            end else begin
                mosi <= 1'b0;  // read phase, line parked low
            end
        end
    end

    // samples the whole frame, only the tail is kept below
    always_ff @(posedge rst) begin
        if (sample_edge) begin
            rx_shift <= {rx_shift[data_w-2:0], miso};
        end
    end

    // first byte to the top, unused bits fall off
    assign rx_aligned = rx_shift << (data_w - rx_bits);

    // first received byte ends up in 7:0
    assign read_data = {rx_aligned[7:0], rx_aligned[15:8],
                        rx_aligned[23:16], rx_aligned[31:24]};

endmodule

//--- spi_master_ctrl.sv
`timescale 1ns/10ps

module spi_master_ctrl (
    input  logic                             rst,
    input  logic                             clk,
    input  logic                             valid,
    output logic                             ready,
    output logic                             accept,
    output logic                             start,
    input  logic                             done,
    input  logic [spi_flash_pkg::data_w-1:0] read_data,
    output logic [spi_flash_pkg::data_w-1:0] data_out,
    output logic                             ss
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_transfer
    } state_t;

    state_t state;

    assign accept = valid && ready;         // valid ignored while busy
    assign start  = (state == st_setup);    // single cycle, setup lasts one clock

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state    <= st_idle;
            ready    <= 1'b1;
            ss       <= 1'b1;
            data_out <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        ready <= 1'b0;
                        state <= st_setup;
                    end
                end
                st_setup: begin
                    ss    <= 1'b0;  // select together with start
                    state <= st_transfer;
                end
                st_transfer: begin
                    if (done) begin
                        ss       <= 1'b1;
                        ready    <= 1'b1;
                        data_out <= read_data;
                        state    <= st_idle;
                    end
                end
                default: begin
                    ss    <= 1'b1;
                    ready <= 1'b1;
                    state <= st_idle;
                end
            endcase
        end
    end

    a_ss_in_transfer: assert property (
        @(posedge rst) disable iff (clk)
        (state == st_transfer) |-> !ss
    );

endmodule

//--- spi_flash_master.sv
`timescale 1ns/10ps

module spi_flash_master (
    input  logic                              rst,
    input  logic                              clk,
    input  logic [spi_flash_pkg::data_w-1:0]  data_in,
    input  logic [spi_flash_pkg::addr_w-1:0]  address,
    input  logic [spi_flash_pkg::cmd_w-1:0]   command,
    input  logic                              valid,
    input  logic [spi_flash_pkg::ctype_w-1:0] comm_type,
    input  logic [spi_flash_pkg::nbits_w-1:0] ndata_bits,
    input  logic [spi_flash_pkg::dummy_w-1:0] dummy_cycles,
    input  logic                              four_byte_addr,
    output logic                              ready,
    output logic [spi_flash_pkg::data_w-1:0]  data_out,
    output logic                              sclk,
    output logic                              ss,
    output logic                              mosi,
    input  logic                              miso
);
    import spi_flash_pkg::*;

    logic               accept;
    logic               start;
    logic               done;
    logic               lead_edge;
    logic               trail_edge;
    logic [frame_w-1:0] tx_frame;
    logic [cycle_w-1:0] tx_bits;
    logic [nbits_w-1:0] rx_bits;
    logic [cycle_w-1:0] total_cycles;
    logic [data_w-1:0]  read_data;

    spi_master_ctrl i_ctrl (
        .rst       (rst),
        .clk       (clk),
        .valid     (valid),
        .ready     (ready),
        .accept    (accept),
        .start     (start),
        .done      (done),
        .read_data (read_data),
        .data_out  (data_out),
        .ss        (ss)
    );

    // request capture, steers the clock generator and the shifter
    spi_frame_regs i_frame_regs (
        .rst            (rst),
        .clk            (clk),
        .accept         (accept),
        .data_in        (data_in),
        .address        (address),
        .command        (command),
        .comm_type      (comm_type),
        .ndata_bits     (ndata_bits),
        .dummy_cycles   (dummy_cycles),
        .four_byte_addr (four_byte_addr),
        .tx_frame       (tx_frame),
        .tx_bits        (tx_bits),
        .rx_bits        (rx_bits),
        .total_cycles   (total_cycles)
    );

    spi_sclk_gen i_sclk_gen (
        .rst          (rst),
        .clk          (clk),
        .start        (start),
        .total_cycles (total_cycles),
        .sclk         (sclk),
        .lead_edge    (lead_edge),
        .trail_edge   (trail_edge),
        .done         (done)
    );

    spi_shift_engine i_shift_engine (
        .rst        (rst),
        .clk        (clk),
        .start      (start),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge),
        .tx_frame   (tx_frame),
        .tx_bits    (tx_bits),
        .rx_bits    (rx_bits),
        .miso       (miso),
        .mosi       (mosi),
        .read_data  (read_data)
    );

endmodule

//--- tb_flash_model.sv
`timescale 1ns/10ps

module tb_flash_model (
    input  logic         ss,
    input  logic         sclk,
    input  logic         mosi,
    input  logic [31:0]  rd_word,     // answered msb first in the read phase
    input  logic [7:0]   rd_start,    // serial cycle where the read phase begins
    output logic         miso,
    output logic [127:0] mosi_bits,   // latest bit in bit 0
    output logic [7:0]   rise_count,
    output logic [7:0]   fall_count
);
    int idx;

    initial begin
        miso       = 1'b0;
        mosi_bits  = '0;
        rise_count = '0;
        fall_count = '0;
        forever begin
            @(negedge ss);
            mosi_bits  = '0;  // new frame
            rise_count = '0;
            fall_count = '0;
            while (ss == 1'b0) begin
                @(posedge sclk or negedge sclk or posedge ss);
                if (ss == 1'b0 && sclk == 1'b1) begin
                    // mode 3, slave samples on the rising edge
                    mosi_bits  = {mosi_bits[126:0], mosi};
                    rise_count = rise_count + 1'b1;
                end else if (ss == 1'b0) begin
                    idx  = fall_count - rd_start;
                    miso = (fall_count >= rd_start && idx < 32) ? rd_word[31 - idx] : 1'b0;
                    fall_count = fall_count + 1'b1;
                end
            end
        end
    end

endmodule

//--- tb_spi_flash_master.sv
`timescale 1ns/10ps

module tb_spi_flash_master;
    import spi_flash_pkg::*;

    localparam int wait_limit = 2000;  // clock cycles per wait

    typedef struct packed {
        logic [127:0]       bits;      // mosi string, last bit in bit 0
        logic [cycle_w-1:0] cycles;
        logic [cycle_w-1:0] rd_start;
        logic [data_w-1:0]  data;
    } expect_t;

    logic               rst = 1'b0;  // clock
    logic               clk;         // reset
    logic [data_w-1:0]  data_in;
    logic [addr_w-1:0]  address;
    logic [cmd_w-1:0]   command;
    logic               valid;
    logic [ctype_w-1:0] comm_type;
    logic [nbits_w-1:0] ndata_bits;
    logic [dummy_w-1:0] dummy_cycles;
    logic               four_byte_addr;
    logic               ready;
    logic [data_w-1:0]  data_out;
    logic               sclk;
    logic               ss;
    logic               mosi;
    logic               miso;
    logic [data_w-1:0]  rd_word;
    logic [cycle_w-1:0] rd_start;
    logic [127:0]       mosi_bits;
    logic [cycle_w-1:0] rise_count;
    logic [cycle_w-1:0] fall_count;
    logic               ready_q = 1'b1;
    expect_t            pending[$];
    int                 seed = 25683;
    int                 checks = 0;
    int                 errors = 0;
    int                 issued = 0;
    int                 compared = 0;
    int                 base_checks = 0;
    int                 base_errors = 0;

    spi_flash_master i_dut (
        .rst (rst), .clk (clk), .data_in (data_in), .address (address),
        .command (command), .valid (valid), .comm_type (comm_type),
        .ndata_bits (ndata_bits), .dummy_cycles (dummy_cycles),
        .four_byte_addr (four_byte_addr), .ready (ready), .data_out (data_out),
        .sclk (sclk), .ss (ss), .mosi (mosi), .miso (miso)
    );

    tb_flash_model i_flash (
        .ss (ss), .sclk (sclk), .mosi (mosi), .rd_word (rd_word), .rd_start (rd_start),
        .miso (miso), .mosi_bits (mosi_bits), .rise_count (rise_count),
        .fall_count (fall_count)
    );

    initial begin
        forever #10 rst = ~rst;
    end

    // expected mosi string, serial clock count and data_out of one request
    function automatic expect_t reference_model(
        input logic [ctype_w-1:0] ctype,
        input logic [cmd_w-1:0]   cmd,
        input logic [addr_w-1:0]  addr,
        input logic [data_w-1:0]  wdata,
        input int                 nbits,
        input int                 dummy,
        input logic               four_byte,
        input logic [data_w-1:0]  word
    );
        expect_t e;
        int      n_addr;
        int      n_tx;
        int      i;
        e      = '0;
        n_addr = 0;
        if (ctype == 2 || ctype == 4 || ctype == 5) begin
            n_addr = four_byte ? 32 : 24;
        end
        for (i = 7; i >= 0; i--) begin
            e.bits = {e.bits[126:0], cmd[i]};
        end
        for (i = n_addr - 1; i >= 0; i--) begin
            e.bits = {e.bits[126:0], addr[i]};
        end
        n_tx = 8 + n_addr;
        if (ctype == 3 || ctype == 4) begin
            // low byte first, each byte msb first
            for (i = 0; i < nbits; i++) begin
                e.bits = {e.bits[126:0], wdata[8 * (i / 8) + 7 - i % 8]};
            end
            n_tx = n_tx + nbits;
        end
        e.rd_start = n_tx + (ctype == 2 ? dummy : 0);
        e.cycles   = e.rd_start;
        if (ctype == 1 || ctype == 2) begin
            e.cycles = e.cycles + nbits;
            for (i = 0; i < nbits; i++) begin
                e.data[8 * (i / 8) + 7 - i % 8] = word[31 - i];  // first byte in 7:0
            end
        end
        e.bits = e.bits << (e.cycles - n_tx);  // mosi low after the last sent bit
        return e;
    endfunction

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t: no %s within %0d clock cycles", $time, what, wait_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic close_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - base_checks,
                 errors - base_errors);
        base_checks = checks;
        base_errors = errors;
    endtask

    // drives one request and returns on the edge that accepts it
    task automatic issue_request(input logic [ctype_w-1:0] ctype, input logic [cmd_w-1:0] cmd,
                                 input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata,
                                 input int nbits, input int dummy, input logic four_byte);
        expect_t           e;
        logic [data_w-1:0] word;
        int                n;
        word = $random(seed);
        e    = reference_model(ctype, cmd, addr, wdata, nbits, dummy, four_byte, word);
        @(posedge rst);
        valid          <= 1'b1;
        comm_type      <= ctype;
        command        <= cmd;
        address        <= addr;
        data_in        <= wdata;
        ndata_bits     <= nbits_w'(nbits);
        dummy_cycles   <= dummy_w'(dummy);
        four_byte_addr <= four_byte;
        rd_word        <= word;
        rd_start       <= e.rd_start;
        n = 0;
        @(negedge rst);
        while (!ready && n < wait_limit) begin
            n++;
            @(negedge rst);
        end
        if (!ready) begin
            abort_on_timeout("ready for a new request");
        end else begin
            @(posedge rst);  // accepting edge
            valid <= 1'b0;
            pending.push_back(e);
            issued++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge rst);
        while (!(ready && compared == issued) && n < wait_limit) begin
            n++;
            @(negedge rst);
        end
        if (!(ready && compared == issued)) begin
            abort_on_timeout("end of transfer");
        end
    endtask

    // compares every finished transfer with the reference
    initial begin
        expect_t e;
        forever begin
            @(negedge rst);
            if (ready && !ready_q) begin
                if (pending.size() == 0) begin
                    errors++;
                    $display("ready rose at %0t with no request outstanding", $time);
                end else begin
                    e = pending.pop_front();
                    check_value("serial clocks with ss low", rise_count, e.cycles);
                    check_value("falling sclk edges", fall_count, e.cycles);
                    check_value("mosi bit string", mosi_bits, e.bits);
                    check_value("data_out", data_out, e.data);
                    check_value("ss after transfer", ss, 1'b1);
                    compared++;
                end
            end
            ready_q = ready;
        end
    end

    initial begin
        int i;
        clk            = 1'b1;
        valid          = 1'b0;
        data_in        = '0;
        address        = '0;
        command        = '0;
        comm_type      = '0;
        ndata_bits     = 6'd8;
        dummy_cycles   = '0;
        four_byte_addr = 1'b0;
        rd_word        = '0;
        rd_start       = '0;
        repeat (2) @(posedge rst);
        clk <= 1'b0;

        @(negedge rst);
        check_value("ready after reset", ready, 1'b1);
        check_value("ss after reset", ss, 1'b1);
        check_value("sclk after reset", sclk, 1'b1);
        check_value("data_out after reset", data_out, '0);
        close_test("test 1 reset state");

        for (i = 0; i < 5; i++) begin
            // codes 6 and 7 fall back to command only
            issue_request(i < 3 ? 0 : i + 3, $random(seed), $random(seed), $random(seed),
                          8, 0, 1'b0);
            wait_idle();
        end
        close_test("test 2 command only");

        for (i = 0; i < 4; i++) begin
            issue_request(5, $random(seed), $random(seed), 0, 8, 0, i % 2);
            wait_idle();
        end
        close_test("test 3 command and address");

        for (i = 0; i < 8; i++) begin
            issue_request(i < 4 ? 3 : 4, $random(seed), $random(seed), $random(seed),
                          8 * (i % 4 + 1), 0, $random(seed));
            wait_idle();
        end
        close_test("test 4 writes");

        for (i = 0; i < 8; i++) begin
            issue_request(i < 4 ? 1 : 2, $random(seed), $random(seed), 0,
                          8 * (i % 4 + 1), $random(seed) & 15, $random(seed));
            wait_idle();
        end
        close_test("test 5 reads");

        // second request held with valid while the first is in flight
        issue_request(4, $random(seed), $random(seed), $random(seed), 32, 0, 1'b1);
        issue_request(2, $random(seed), $random(seed), 0, 16, 5, 1'b0);
        wait_idle();
        close_test("test 6 valid held while busy");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
spi_flash_pkg.sv
spi_clock_pkg.sv
spi_sclk_gen.sv
spi_frame_regs.sv
spi_shift_engine.sv
spi_master_ctrl.sv
spi_flash_master.sv
tb_flash_model.sv
tb_spi_flash_master.sv

//--- Bender.yml
package:
  name: spi_flash_master

sources:
  - spi_flash_pkg.sv
  - spi_clock_pkg.sv
  - spi_sclk_gen.sv
  - spi_frame_regs.sv
  - spi_shift_engine.sv
  - spi_master_ctrl.sv
  - spi_flash_master.sv
  - target: simulation
    files:
      - tb_flash_model.sv
      - tb_spi_flash_master.sv
